// File: design/sys_pkg.sv
// System-control subsystem package
// Shared bus types, response codes, address map, register
// offsets and reset defaults for the single-beat AXI-lite fabric
package sys_pkg;

	// bus field types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [3:0]  id_t;
	typedef logic [1:0]  resp_t;

	// response codes
	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_DECERR = 2'd3;

	// scratch SRAM window
	localparam addr_t SRAM_BASE  = 32'h2000_0000;
	localparam addr_t SRAM_LIMIT = 32'h2000_0fff;

	// system-control register window
	localparam addr_t SYSCTRL_BASE  = 32'hf100_0000;
	localparam addr_t SYSCTRL_LIMIT = 32'hf100_0fff;

	// word address width of the scratch SRAM
	localparam int SRAM_ADDR_BITS = 10;

	// register word indices, from address bits 3:2
	localparam logic [1:0] REG_LED    = 2'd0;
	localparam logic [1:0] REG_ACTIVE = 2'd1;
	localparam logic [1:0] REG_IDLE   = 2'd2;
	localparam logic [1:0] REG_RESET  = 2'd3;

	// reset-sequencer defaults
	localparam data_t IDLE_DEFAULT   = 32'd200;
	// zero keeps the sub-system running forever
	localparam data_t ACTIVE_DEFAULT = 32'd0;

endpackage

// File: design/sys_reset_seq.sv
// Sub-system reset sequencer
// Holds the sub-system in reset for IDLE+1 cycles, then lets it
// run until a soft-reset request or until ACTIVE+1 cycles expire
module sys_reset_seq
	import sys_pkg::*;
(
	input  logic  i_core_clk,
	input  logic  i_rst_n,
	input  data_t i_idle_cnt,
	input  data_t i_active_cnt,
	input  logic  i_soft_rst_req,
	output logic  o_sub_rst_n
);

	typedef enum logic {
		ST_HOLD,
		ST_RUN
	} seq_state_e;

	seq_state_e state_q;
	data_t      cnt_q;

	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			state_q <= ST_HOLD;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				ST_HOLD: begin
					// idle and active are sampled live
					if (cnt_q == i_idle_cnt) begin
						cnt_q   <= '0;
						state_q <= ST_RUN;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end

				ST_RUN: begin
					if (i_soft_rst_req) begin
						cnt_q   <= '0;
						state_q <= ST_HOLD;
					end else if (i_active_cnt != '0 && cnt_q == i_active_cnt) begin
						// run window used up
						cnt_q   <= '0;
						state_q <= ST_HOLD;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end

				default: begin
					cnt_q   <= '0;
					state_q <= ST_HOLD;
				end
			endcase
		end
	end

	// sub-system leaves reset only in the run state
	assign o_sub_rst_n = (state_q == ST_RUN);

endmodule

// File: design/sys_ctrl_regs.sv
// System-control register block
// AXI-lite slave with LED, ACTIVE and IDLE registers and a
// RESET/STATUS register; a write there requests a soft reset,
// a read returns the current sub-system reset state
module sys_ctrl_regs
	import sys_pkg::*;
(
	input  logic       i_core_clk,
	input  logic       i_rst_n,
	input  logic       i_awvalid,
	output logic       o_awready,
	input  addr_t      i_awaddr,
	input  id_t        i_awid,
	input  logic       i_wvalid,
	output logic       o_wready,
	input  data_t      i_wdata,
	output logic       o_bvalid,
	input  logic       i_bready,
	output id_t        o_bid,
	output resp_t      o_bresp,
	input  logic       i_arvalid,
	output logic       o_arready,
	input  addr_t      i_araddr,
	input  id_t        i_arid,
	output logic       o_rvalid,
	input  logic       i_rready,
	output data_t      o_rdata,
	output id_t        o_rid,
	output resp_t      o_rresp,
	input  logic       i_sub_rst_n,
	output logic [3:0] o_led,
	output data_t      o_idle_cnt,
	output data_t      o_active_cnt,
	output logic       o_soft_rst_req
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	wr_state_e  wr_state_q;
	logic [1:0] wr_reg_q;
	id_t        wr_id_q;
	data_t      led_q;
	data_t      active_q;
	data_t      idle_q;
	logic       rvalid_q;
	data_t      rdata_q;
	id_t        rid_q;

	assign o_awready = (wr_state_q == WR_IDLE);
	assign o_wready  = (wr_state_q == WR_DATA);
	assign o_bvalid  = (wr_state_q == WR_RESP);
	assign o_bid     = wr_id_q;
	assign o_bresp   = RESP_OKAY;

	// write FSM, full words only
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			wr_state_q     <= WR_IDLE;
			led_q          <= '0;
			active_q       <= ACTIVE_DEFAULT;
			idle_q         <= IDLE_DEFAULT;
			o_soft_rst_req <= 1'b0;
		end else begin
			o_soft_rst_req <= 1'b0;
			case (wr_state_q)
				WR_IDLE: begin
					if (i_awvalid)
						wr_state_q <= WR_DATA;
				end

				WR_DATA: begin
					if (i_wvalid) begin
						case (wr_reg_q)
							REG_LED:    led_q <= i_wdata;
							REG_ACTIVE: active_q <= i_wdata;
							REG_IDLE:   idle_q <= i_wdata;
							// data is ignored, only the request matters
							REG_RESET:  o_soft_rst_req <= 1'b1;
							default:    led_q <= led_q;
						endcase
						wr_state_q <= WR_RESP;
					end
				end

				WR_RESP: begin
					if (i_bready)
						wr_state_q <= WR_IDLE;
				end

				default: wr_state_q <= WR_IDLE;
			endcase
		end
	end

	// address and id held through the data and response phases
	always_ff @(posedge i_core_clk) begin
		if (o_awready && i_awvalid) begin
			wr_reg_q <= i_awaddr[3:2];
			wr_id_q  <= i_awid;
		end
	end

	// read side, one response slot
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			rvalid_q <= 1'b0;
		end else if (o_arready && i_arvalid) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && i_rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_core_clk) begin
		if (o_arready && i_arvalid) begin
			rid_q <= i_arid;
			case (i_araddr[3:2])
				REG_LED:    rdata_q <= led_q;
				REG_ACTIVE: rdata_q <= active_q;
				REG_IDLE:   rdata_q <= idle_q;
				default:    rdata_q <= {31'd0, i_sub_rst_n};
			endcase
		end
	end

	assign o_arready = !rvalid_q;
	assign o_rvalid  = rvalid_q;
	assign o_rdata   = rdata_q;
	assign o_rid     = rid_q;
	assign o_rresp   = RESP_OKAY;

	assign o_led        = led_q[3:0];
	assign o_idle_cnt   = idle_q;
	assign o_active_cnt = active_q;

endmodule

// File: design/axi_lite_decoder.sv
// AXI-lite address decoder, one master to two slaves
// Routes each single-beat access to the scratch SRAM (s0) or the
// system-control registers (s1); unmapped accesses are answered
// here with DECERR. One read and one write may be in flight.
module axi_lite_decoder
	import sys_pkg::*;
(
	input  logic  i_core_clk,
	input  logic  i_rst_n,
	// master side
	input  logic  i_awvalid,
	output logic  o_awready,
	input  addr_t i_awaddr,
	input  id_t   i_awid,
	input  logic  i_wvalid,
	output logic  o_wready,
	input  data_t i_wdata,
	input  strb_t i_wstrb,
	output logic  o_bvalid,
	input  logic  i_bready,
	output id_t   o_bid,
	output resp_t o_bresp,
	input  logic  i_arvalid,
	output logic  o_arready,
	input  addr_t i_araddr,
	input  id_t   i_arid,
	output logic  o_rvalid,
	input  logic  i_rready,
	output data_t o_rdata,
	output id_t   o_rid,
	output resp_t o_rresp,
	// scratch SRAM
	output logic  o_s0_awvalid,
	input  logic  i_s0_awready,
	output addr_t o_s0_awaddr,
	output id_t   o_s0_awid,
	output logic  o_s0_wvalid,
	input  logic  i_s0_wready,
	output data_t o_s0_wdata,
	output strb_t o_s0_wstrb,
	input  logic  i_s0_bvalid,
	output logic  o_s0_bready,
	input  id_t   i_s0_bid,
	input  resp_t i_s0_bresp,
	output logic  o_s0_arvalid,
	input  logic  i_s0_arready,
	output addr_t o_s0_araddr,
	output id_t   o_s0_arid,
	input  logic  i_s0_rvalid,
	output logic  o_s0_rready,
	input  data_t i_s0_rdata,
	input  id_t   i_s0_rid,
	input  resp_t i_s0_rresp,
	// register block, whole words so no strobes
	output logic  o_s1_awvalid,
	input  logic  i_s1_awready,
	output addr_t o_s1_awaddr,
	output id_t   o_s1_awid,
	output logic  o_s1_wvalid,
	input  logic  i_s1_wready,
	output data_t o_s1_wdata,
	input  logic  i_s1_bvalid,
	output logic  o_s1_bready,
	input  id_t   i_s1_bid,
	input  resp_t i_s1_bresp,
	output logic  o_s1_arvalid,
	input  logic  i_s1_arready,
	output addr_t o_s1_araddr,
	output id_t   o_s1_arid,
	input  logic  i_s1_rvalid,
	output logic  o_s1_rready,
	input  data_t i_s1_rdata,
	input  id_t   i_s1_rid,
	input  resp_t i_s1_rresp
);

	typedef enum logic [1:0] {
		TGT_SRAM,
		TGT_REGS,
		TGT_ERR
	} tgt_e;

	function automatic tgt_e decode(input addr_t addr);
		if (addr >= SRAM_BASE && addr <= SRAM_LIMIT)
			return TGT_SRAM;
		if (addr >= SYSCTRL_BASE && addr <= SYSCTRL_LIMIT)
			return TGT_REGS;
		return TGT_ERR;
	endfunction

	tgt_e aw_tgt;
	tgt_e wr_tgt_q;
	logic wr_busy_q;
	logic err_wdone_q;
	id_t  err_bid_q;
	tgt_e ar_tgt;
	tgt_e rd_tgt_q;
	logic rd_busy_q;
	id_t  err_rid_q;

	assign aw_tgt = decode(i_awaddr);
	assign ar_tgt = decode(i_araddr);

	// request payloads go to both slaves, only valids are steered
	assign o_s0_awaddr = i_awaddr;
	assign o_s0_awid   = i_awid;
	assign o_s0_wdata  = i_wdata;
	assign o_s0_wstrb  = i_wstrb;
	assign o_s0_araddr = i_araddr;
	assign o_s0_arid   = i_arid;
	assign o_s1_awaddr = i_awaddr;
	assign o_s1_awid   = i_awid;
	assign o_s1_wdata  = i_wdata;
	assign o_s1_araddr = i_araddr;
	assign o_s1_arid   = i_arid;

	assign o_s0_awvalid = i_awvalid && !wr_busy_q && aw_tgt == TGT_SRAM;
	assign o_s1_awvalid = i_awvalid && !wr_busy_q && aw_tgt == TGT_REGS;
	assign o_s0_wvalid  = i_wvalid && wr_busy_q && wr_tgt_q == TGT_SRAM;
	assign o_s1_wvalid  = i_wvalid && wr_busy_q && wr_tgt_q == TGT_REGS;
	assign o_s0_bready  = i_bready && wr_busy_q && wr_tgt_q == TGT_SRAM;
	assign o_s1_bready  = i_bready && wr_busy_q && wr_tgt_q == TGT_REGS;
	assign o_s0_arvalid = i_arvalid && !rd_busy_q && ar_tgt == TGT_SRAM;
	assign o_s1_arvalid = i_arvalid && !rd_busy_q && ar_tgt == TGT_REGS;
	assign o_s0_rready  = i_rready && rd_busy_q && rd_tgt_q == TGT_SRAM;
	assign o_s1_rready  = i_rready && rd_busy_q && rd_tgt_q == TGT_REGS;

	// write path muxing
	always_comb begin
		o_awready = 1'b0;
		o_wready  = 1'b0;
		o_bvalid  = 1'b0;
		o_bid     = err_bid_q;
		o_bresp   = RESP_DECERR;
		if (!wr_busy_q) begin
			case (aw_tgt)
				TGT_SRAM: o_awready = i_s0_awready;
				TGT_REGS: o_awready = i_s1_awready;
				default:  o_awready = 1'b1;
			endcase
		end else begin
			case (wr_tgt_q)
				TGT_SRAM: begin
					o_wready = i_s0_wready;
					o_bvalid = i_s0_bvalid;
					o_bid    = i_s0_bid;
					o_bresp  = i_s0_bresp;
				end
				TGT_REGS: begin
					o_wready = i_s1_wready;
					o_bvalid = i_s1_bvalid;
					o_bid    = i_s1_bid;
					o_bresp  = i_s1_bresp;
				end
				default: begin
					// local error slave swallows one data beat
					o_wready = !err_wdone_q;
					o_bvalid = err_wdone_q;
				end
			endcase
		end
	end

	// read path muxing
	always_comb begin
		o_arready = 1'b0;
		o_rvalid  = 1'b0;
		o_rdata   = '0;
		o_rid     = err_rid_q;
		o_rresp   = RESP_DECERR;
		if (!rd_busy_q) begin
			case (ar_tgt)
				TGT_SRAM: o_arready = i_s0_arready;
				TGT_REGS: o_arready = i_s1_arready;
				default:  o_arready = 1'b1;
			endcase
		end else begin
			case (rd_tgt_q)
				TGT_SRAM: begin
					o_rvalid = i_s0_rvalid;
					o_rdata  = i_s0_rdata;
					o_rid    = i_s0_rid;
					o_rresp  = i_s0_rresp;
				end
				TGT_REGS: begin
					o_rvalid = i_s1_rvalid;
					o_rdata  = i_s1_rdata;
					o_rid    = i_s1_rid;
					o_rresp  = i_s1_rresp;
				end
				default: o_rvalid = 1'b1;
			endcase
		end
	end

	// target tracking
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			wr_busy_q   <= 1'b0;
			wr_tgt_q    <= TGT_SRAM;
			err_wdone_q <= 1'b0;
			rd_busy_q   <= 1'b0;
			rd_tgt_q    <= TGT_SRAM;
		end else begin
			if (i_awvalid && o_awready) begin
				wr_busy_q <= 1'b1;
				wr_tgt_q  <= aw_tgt;
			end
			if (wr_busy_q && wr_tgt_q == TGT_ERR && i_wvalid)
				err_wdone_q <= 1'b1;
			if (o_bvalid && i_bready) begin
				wr_busy_q   <= 1'b0;
				err_wdone_q <= 1'b0;
			end

			if (i_arvalid && o_arready) begin
				rd_busy_q <= 1'b1;
				rd_tgt_q  <= ar_tgt;
			end else if (o_rvalid && i_rready) begin
				rd_busy_q <= 1'b0;
			end
		end
	end

	// ids for the local error responses
	always_ff @(posedge i_core_clk) begin
		if (i_awvalid && o_awready)
			err_bid_q <= i_awid;
		if (i_arvalid && o_arready)
			err_rid_q <= i_arid;
	end

endmodule

// File: design/axi_lite_sram.sv
// Scratch SRAM behind a single-beat AXI-lite slave port
// Word addressed from bits 11:2, writes honour the byte strobes.
// Responses come one cycle after the accepting handshake.
module axi_lite_sram
	import sys_pkg::*;
(
	input  logic  i_core_clk,
	input  logic  i_rst_n,
	input  logic  i_awvalid,
	output logic  o_awready,
	input  addr_t i_awaddr,
	input  id_t   i_awid,
	input  logic  i_wvalid,
	output logic  o_wready,
	input  data_t i_wdata,
	input  strb_t i_wstrb,
	output logic  o_bvalid,
	input  logic  i_bready,
	output id_t   o_bid,
	output resp_t o_bresp,
	input  logic  i_arvalid,
	output logic  o_arready,
	input  addr_t i_araddr,
	input  id_t   i_arid,
	output logic  o_rvalid,
	input  logic  i_rready,
	output data_t o_rdata,
	output id_t   o_rid,
	output resp_t o_rresp
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	data_t mem [2**SRAM_ADDR_BITS];

	wr_state_e                 wr_state_q;
	logic [SRAM_ADDR_BITS-1:0] wr_idx_q;
	id_t                       wr_id_q;
	logic                      rvalid_q;
	data_t                     rdata_q;
	id_t                       rid_q;

	assign o_awready = (wr_state_q == WR_IDLE);
	assign o_wready  = (wr_state_q == WR_DATA);
	assign o_bvalid  = (wr_state_q == WR_RESP);
	assign o_bid     = wr_id_q;
	assign o_bresp   = RESP_OKAY;

	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			wr_state_q <= WR_IDLE;
		end else begin
			case (wr_state_q)
				WR_IDLE: if (i_awvalid) wr_state_q <= WR_DATA;
				WR_DATA: if (i_wvalid) wr_state_q <= WR_RESP;
				WR_RESP: if (i_bready) wr_state_q <= WR_IDLE;
				default: wr_state_q <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_core_clk) begin
		if (o_awready && i_awvalid) begin
			wr_idx_q <= i_awaddr[SRAM_ADDR_BITS+1:2];
			wr_id_q  <= i_awid;
		end
		// bytewise update
		if (o_wready && i_wvalid) begin
			for (int b = 0; b < 4; b++) begin
				if (i_wstrb[b])
					mem[wr_idx_q][8*b +: 8] <= i_wdata[8*b +: 8];
			end
		end
	end

	// read slot, held until rready
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			rvalid_q <= 1'b0;
		end else if (o_arready && i_arvalid) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && i_rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_core_clk) begin
		if (o_arready && i_arvalid) begin
			rdata_q <= mem[i_araddr[SRAM_ADDR_BITS+1:2]];
			rid_q   <= i_arid;
		end
	end

	assign o_arready = !rvalid_q;
	assign o_rvalid  = rvalid_q;
	assign o_rdata   = rdata_q;
	assign o_rid     = rid_q;
	assign o_rresp   = RESP_OKAY;

endmodule

// File: design/sys_top.sv
// System-control subsystem top level
// External AXI-lite master port into the address decoder, which
// serves the scratch SRAM and the control registers; the reset
// sequencer drives the sub-system reset and status
module sys_top
	import sys_pkg::*;
(
	input  logic       i_core_clk,
	input  logic       i_rst_n,
	input  logic       i_awvalid,
	output logic       o_awready,
	input  addr_t      i_awaddr,
	input  id_t        i_awid,
	input  logic       i_wvalid,
	output logic       o_wready,
	input  data_t      i_wdata,
	input  strb_t      i_wstrb,
	output logic       o_bvalid,
	input  logic       i_bready,
	output id_t        o_bid,
	output resp_t      o_bresp,
	input  logic       i_arvalid,
	output logic       o_arready,
	input  addr_t      i_araddr,
	input  id_t        i_arid,
	output logic       o_rvalid,
	input  logic       i_rready,
	output data_t      o_rdata,
	output id_t        o_rid,
	output resp_t      o_rresp,
	output logic       o_sub_rst_n,
	output logic [3:0] o_led
);

	// decoder to SRAM
	logic  s0_awvalid, s0_awready, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
	logic  s0_arvalid, s0_arready, s0_rvalid, s0_rready;
	addr_t s0_awaddr, s0_araddr;
	id_t   s0_awid, s0_bid, s0_arid, s0_rid;
	data_t s0_wdata, s0_rdata;
	strb_t s0_wstrb;
	resp_t s0_bresp, s0_rresp;

	// decoder to register block
	logic  s1_awvalid, s1_awready, s1_wvalid, s1_wready, s1_bvalid, s1_bready;
	logic  s1_arvalid, s1_arready, s1_rvalid, s1_rready;
	addr_t s1_awaddr, s1_araddr;
	id_t   s1_awid, s1_bid, s1_arid, s1_rid;
	data_t s1_wdata, s1_rdata;
	resp_t s1_bresp, s1_rresp;

	// register block to sequencer
	data_t idle_cnt;
	data_t active_cnt;
	logic  soft_rst_req;
	logic  sub_rst_n;

	axi_lite_decoder u_decoder (
		.i_core_clk   (i_core_clk),
		.i_rst_n      (i_rst_n),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_awaddr     (i_awaddr),
		.i_awid       (i_awid),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.i_wdata      (i_wdata),
		.i_wstrb      (i_wstrb),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.o_bid        (o_bid),
		.o_bresp      (o_bresp),
		.i_arvalid    (i_arvalid),
		.o_arready    (o_arready),
		.i_araddr     (i_araddr),
		.i_arid       (i_arid),
		.o_rvalid     (o_rvalid),
		.i_rready     (i_rready),
		.o_rdata      (o_rdata),
		.o_rid        (o_rid),
		.o_rresp      (o_rresp),
		.o_s0_awvalid (s0_awvalid),
		.i_s0_awready (s0_awready),
		.o_s0_awaddr  (s0_awaddr),
		.o_s0_awid    (s0_awid),
		.o_s0_wvalid  (s0_wvalid),
		.i_s0_wready  (s0_wready),
		.o_s0_wdata   (s0_wdata),
		.o_s0_wstrb   (s0_wstrb),
		.i_s0_bvalid  (s0_bvalid),
		.o_s0_bready  (s0_bready),
		.i_s0_bid     (s0_bid),
		.i_s0_bresp   (s0_bresp),
		.o_s0_arvalid (s0_arvalid),
		.i_s0_arready (s0_arready),
		.o_s0_araddr  (s0_araddr),
		.o_s0_arid    (s0_arid),
		.i_s0_rvalid  (s0_rvalid),
		.o_s0_rready  (s0_rready),
		.i_s0_rdata   (s0_rdata),
		.i_s0_rid     (s0_rid),
		.i_s0_rresp   (s0_rresp),
		.o_s1_awvalid (s1_awvalid),
		.i_s1_awready (s1_awready),
		.o_s1_awaddr  (s1_awaddr),
		.o_s1_awid    (s1_awid),
		.o_s1_wvalid  (s1_wvalid),
		.i_s1_wready  (s1_wready),
		.o_s1_wdata   (s1_wdata),
		.i_s1_bvalid  (s1_bvalid),
		.o_s1_bready  (s1_bready),
		.i_s1_bid     (s1_bid),
		.i_s1_bresp   (s1_bresp),
		.o_s1_arvalid (s1_arvalid),
		.i_s1_arready (s1_arready),
		.o_s1_araddr  (s1_araddr),
		.o_s1_arid    (s1_arid),
		.i_s1_rvalid  (s1_rvalid),
		.o_s1_rready  (s1_rready),
		.i_s1_rdata   (s1_rdata),
		.i_s1_rid     (s1_rid),
		.i_s1_rresp   (s1_rresp)
	);

	axi_lite_sram u_sram (
		.i_core_clk (i_core_clk),
		.i_rst_n    (i_rst_n),
		.i_awvalid  (s0_awvalid),
		.o_awready  (s0_awready),
		.i_awaddr   (s0_awaddr),
		.i_awid     (s0_awid),
		.i_wvalid   (s0_wvalid),
		.o_wready   (s0_wready),
		.i_wdata    (s0_wdata),
		.i_wstrb    (s0_wstrb),
		.o_bvalid   (s0_bvalid),
		.i_bready   (s0_bready),
		.o_bid      (s0_bid),
		.o_bresp    (s0_bresp),
		.i_arvalid  (s0_arvalid),
		.o_arready  (s0_arready),
		.i_araddr   (s0_araddr),
		.i_arid     (s0_arid),
		.o_rvalid   (s0_rvalid),
		.i_rready   (s0_rready),
		.o_rdata    (s0_rdata),
		.o_rid      (s0_rid),
		.o_rresp    (s0_rresp)
	);

	sys_ctrl_regs u_ctrl_regs (
		.i_core_clk     (i_core_clk),
		.i_rst_n        (i_rst_n),
		.i_awvalid      (s1_awvalid),
		.o_awready      (s1_awready),
		.i_awaddr       (s1_awaddr),
		.i_awid         (s1_awid),
		.i_wvalid       (s1_wvalid),
		.o_wready       (s1_wready),
		.i_wdata        (s1_wdata),
		.o_bvalid       (s1_bvalid),
		.i_bready       (s1_bready),
		.o_bid          (s1_bid),
		.o_bresp        (s1_bresp),
		.i_arvalid      (s1_arvalid),
		.o_arready      (s1_arready),
		.i_araddr       (s1_araddr),
		.i_arid         (s1_arid),
		.o_rvalid       (s1_rvalid),
		.i_rready       (s1_rready),
		.o_rdata        (s1_rdata),
		.o_rid          (s1_rid),
		.o_rresp        (s1_rresp),
		.i_sub_rst_n    (sub_rst_n),
		.o_led          (o_led),
		.o_idle_cnt     (idle_cnt),
		.o_active_cnt   (active_cnt),
		.o_soft_rst_req (soft_rst_req)
	);

	sys_reset_seq u_reset_seq (
		.i_core_clk     (i_core_clk),
		.i_rst_n        (i_rst_n),
		.i_idle_cnt     (idle_cnt),
		.i_active_cnt   (active_cnt),
		.i_soft_rst_req (soft_rst_req),
		.o_sub_rst_n    (sub_rst_n)
	);

	assign o_sub_rst_n = sub_rst_n;

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock and reset source
// 40 ns core clock, reset held low for the first five rising edges
module tb_clock_gen (
	output logic o_core_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_core_clk = 1'b0;
		forever #20 o_core_clk = ~o_core_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (5) @(posedge o_core_clk);
		o_rst_n <= 1'b1;
	end

endmodule

// File: dv/tb_sys_top.sv
// System-control subsystem testbench
// Random AXI-lite traffic to the SRAM, the control registers and
// unmapped space, checked against a reference model that also
// tracks the sub-system reset sequencer cycle by cycle
module tb_sys_top
	import sys_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned SEED       = 32'h3dce_f40a;
	localparam int          N_WORDS    = 64;
	localparam int          N_SRAM     = 200;
	localparam int          N_REGS     = 40;
	localparam int          N_UNMAP    = 40;
	localparam int          MAX_IDLE   = 9;
	localparam int          MAX_ACTIVE = 9;
	localparam int          N_TXN      = 2 * N_WORDS + N_SRAM + 2 * N_REGS + N_UNMAP + 16;
	localparam int          WD_CYCLES  = N_TXN * 40 + int'(IDLE_DEFAULT)
		+ 8 * (MAX_IDLE + MAX_ACTIVE + 2);

	logic       core_clk;
	logic       rst_n;
	logic       awvalid, wvalid, bready, arvalid, rready;
	addr_t      awaddr, araddr;
	id_t        awid, arid;
	data_t      wdata;
	strb_t      wstrb;
	logic       o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_sub_rst_n;
	id_t        o_bid, o_rid;
	resp_t      o_bresp, o_rresp;
	data_t      o_rdata;
	logic [3:0] o_led;

	// reference model
	data_t       sram_model [1024];
	data_t       m_led, m_active, m_idle, m_cnt;
	logic        m_run, m_soft_req;
	int unsigned base_word;
	int          data_errs, resp_errs, id_errs, bit_errs;

	tb_clock_gen u_clock_gen (
		.o_core_clk (core_clk),
		.o_rst_n    (rst_n)
	);

	sys_top dut (
		.i_core_clk (core_clk),  .i_rst_n   (rst_n),
		.i_awvalid  (awvalid),   .o_awready (o_awready),
		.i_awaddr   (awaddr),    .i_awid    (awid),
		.i_wvalid   (wvalid),    .o_wready  (o_wready),
		.i_wdata    (wdata),     .i_wstrb   (wstrb),
		.o_bvalid   (o_bvalid),  .i_bready  (bready),
		.o_bid      (o_bid),     .o_bresp   (o_bresp),
		.i_arvalid  (arvalid),   .o_arready (o_arready),
		.i_araddr   (araddr),    .i_arid    (arid),
		.o_rvalid   (o_rvalid),  .i_rready  (rready),
		.o_rdata    (o_rdata),   .o_rid     (o_rid),
		.o_rresp    (o_rresp),   .o_sub_rst_n (o_sub_rst_n),
		.o_led      (o_led)
	);

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			data_errs++;
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp, input resp_t act);
		if (act !== exp) begin
			resp_errs++;
			$display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_id(input string name, input id_t exp, input id_t act);
		if (act !== exp) begin
			id_errs++;
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			bit_errs++;
			$display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	function automatic logic sram_hit(input addr_t a);
		return a >= SRAM_BASE && a <= SRAM_LIMIT;
	endfunction

	function automatic logic regs_hit(input addr_t a);
		return a >= SYSCTRL_BASE && a <= SYSCTRL_LIMIT;
	endfunction

	function automatic resp_t expect_resp(input addr_t a);
		return (sram_hit(a) || regs_hit(a)) ? RESP_OKAY : RESP_DECERR;
	endfunction

	// read value seen by a read accepted at the current edge
	function automatic data_t expect_rdata(input addr_t a);
		if (sram_hit(a))
			return sram_model[a[11:2]];
		if (!regs_hit(a))
			return '0;
		case (a[3:2])
			REG_LED:    return m_led;
			REG_ACTIVE: return m_active;
			REG_IDLE:   return m_idle;
			default:    return {31'd0, m_run};
		endcase
	endfunction

	function automatic data_t fill_word(input addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h6b3c_19e5;
	endfunction

	function automatic addr_t sram_addr_rand();
		int unsigned word;
		int unsigned r;
		addr_t       a;
		word = base_word + $urandom_range(0, N_WORDS - 1);
		r = $urandom;
		a = SRAM_BASE;
		a[11:2] = word[9:0];
		a[1:0] = r[1:0];
		return a;
	endfunction

	// higher bits in the window alias onto the four registers
	function automatic addr_t reg_addr_rand(input logic [1:0] sel);
		int unsigned r;
		addr_t       a;
		r = $urandom;
		a = SYSCTRL_BASE;
		a[11:4] = r[11:4];
		a[3:2] = sel;
		a[1:0] = r[1:0];
		return a;
	endfunction

	function automatic addr_t unmapped_addr();
		addr_t a;
		do begin
			a = $urandom;
		end while (sram_hit(a) || regs_hit(a));
		return a;
	endfunction

	task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb,
		input bit allow_bp);
		int unsigned r;
		int unsigned gap;
		id_t         id;
		r = $urandom;
		id = r[3:0];
		repeat ($urandom_range(0, 2)) @(posedge core_clk);
		awaddr  <= addr;
		awid    <= id;
		awvalid <= 1'b1;
		do @(posedge core_clk); while (!o_awready);
		awvalid <= 1'b0;
		wdata   <= data;
		wstrb   <= strb;
		wvalid  <= 1'b1;
		do @(posedge core_clk); while (!o_wready);
		wvalid <= 1'b0;
		gap = allow_bp ? $urandom_range(0, 3) : 0;
		repeat (gap) @(posedge core_clk);
		bready <= 1'b1;
		do @(posedge core_clk); while (!o_bvalid);
		bready <= 1'b0;
		check_id("o_bid", id, o_bid);
		check_resp("o_bresp", expect_resp(addr), o_bresp);
	endtask

	task automatic read_txn(input addr_t addr);
		int unsigned r;
		int unsigned gap;
		id_t         id;
		data_t       exp;
		r = $urandom;
		id = r[3:0];
		repeat ($urandom_range(0, 2)) @(posedge core_clk);
		araddr  <= addr;
		arid    <= id;
		arvalid <= 1'b1;
		do @(posedge core_clk); while (!o_arready);
		exp = expect_rdata(addr);
		arvalid <= 1'b0;
		gap = $urandom_range(0, 3);
		repeat (gap) @(posedge core_clk);
		rready <= 1'b1;
		do @(posedge core_clk); while (!o_rvalid);
		rready <= 1'b0;
		check_data("o_rdata", exp, o_rdata);
		check_id("o_rid", id, o_rid);
		check_resp("o_rresp", expect_resp(addr), o_rresp);
	endtask

	task automatic print_counts();
		$display("error counts: data %0d, resp %0d, id %0d, bit %0d",
			data_errs, resp_errs, id_errs, bit_errs);
	endtask

	// model update and per-cycle output checks
	always @(posedge core_clk) begin : model_step
		data_t merged;
		if (!rst_n) begin
			m_led      <= '0;
			m_active   <= ACTIVE_DEFAULT;
			m_idle     <= IDLE_DEFAULT;
			m_run      <= 1'b0;
			m_cnt      <= '0;
			m_soft_req <= 1'b0;
		end else begin
			check_bit("o_sub_rst_n", m_run, o_sub_rst_n);
			for (int i = 0; i < 4; i++)
				check_bit($sformatf("o_led[%0d]", i), m_led[i], o_led[i]);
			// hold for idle+1 cycles and run until soft reset or active+1 cycles
			if (!m_run) begin
				if (m_cnt == m_idle) begin
					m_cnt <= '0;
					m_run <= 1'b1;
				end else begin
					m_cnt <= m_cnt + 1;
				end
			end else if (m_soft_req || (m_active != '0 && m_cnt == m_active)) begin
				m_cnt <= '0;
				m_run <= 1'b0;
			end else begin
				m_cnt <= m_cnt + 1;
			end
			m_soft_req <= 1'b0;
			if (wvalid && o_wready) begin
				if (sram_hit(awaddr)) begin
					merged = sram_model[awaddr[11:2]];
					for (int b = 0; b < 4; b++)
						if (wstrb[b])
							merged[8*b +: 8] = wdata[8*b +: 8];
					sram_model[awaddr[11:2]] <= merged;
				end else if (regs_hit(awaddr)) begin
					case (awaddr[3:2])
						REG_LED:    m_led <= wdata;
						REG_ACTIVE: m_active <= wdata;
						REG_IDLE:   m_idle <= wdata;
						default:    m_soft_req <= 1'b1;
					endcase
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WD_CYCLES) @(posedge core_clk);
		$display("timeout: run did not finish within %0d clock cycles", WD_CYCLES);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		int unsigned r;
		int          n;
		int unsigned idle_small;
		int unsigned active_small;
		logic [1:0]  sel;
		addr_t       a;
		r = $urandom(SEED);
		awvalid = 1'b0;
		awaddr  = '0;
		awid    = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		arid    = '0;
		rready  = 1'b0;
		data_errs = 0;
		resp_errs = 0;
		id_errs   = 0;
		bit_errs  = 0;

		// power-on hold length
		do @(posedge core_clk); while (!rst_n);
		// bus idle after reset
		check_bit("o_awready", 1'b1, o_awready);
		check_bit("o_arready", 1'b1, o_arready);
		check_bit("o_wready", 1'b0, o_wready);
		check_bit("o_bvalid", 1'b0, o_bvalid);
		check_bit("o_rvalid", 1'b0, o_rvalid);
		n = 0;
		while (!o_sub_rst_n) begin
			n++;
			@(posedge core_clk);
		end
		check_data("power-on low cycles", IDLE_DEFAULT + 1, n);

		// preload a window of SRAM and run random traffic inside it
		base_word = $urandom_range(0, 1024 - N_WORDS);
		for (int i = 0; i < N_WORDS; i++) begin
			a = SRAM_BASE + ((base_word + i) << 2);
			write_txn(a, fill_word(a), 4'hf, 1'b1);
		end
		repeat (N_SRAM) begin
			r = $urandom;
			if (r[0])
				write_txn(sram_addr_rand(), $urandom, r[7:4], 1'b1);
			else
				read_txn(sram_addr_rand());
		end

		// register writes with read-back
		repeat (N_REGS) begin
			r = $urandom;
			sel = r[1:0];
			if (sel == REG_RESET || r[2]) begin
				read_txn(reg_addr_rand(sel));
			end else begin
				r = $urandom;
				// active too large to expire during the run
				if (sel == REG_ACTIVE)
					r[31] = 1'b1;
				write_txn(reg_addr_rand(sel), r, $urandom_range(0, 15), 1'b1);
				read_txn(reg_addr_rand(sel));
			end
		end
		write_txn(reg_addr_rand(REG_ACTIVE), '0, 4'hf, 1'b1);

		repeat (N_UNMAP) begin
			r = $urandom;
			if (r[0])
				write_txn(unmapped_addr(), $urandom, r[7:4], 1'b1);
			else
				read_txn(unmapped_addr());
		end

		// soft reset with a short idle time
		idle_small = $urandom_range(2, MAX_IDLE);
		write_txn(reg_addr_rand(REG_IDLE), idle_small, 4'hf, 1'b1);
		write_txn(reg_addr_rand(REG_RESET), $urandom, 4'hf, 1'b0);
		@(posedge core_clk);
		n = 0;
		while (!o_sub_rst_n) begin
			n++;
			@(posedge core_clk);
		end
		check_data("soft reset low cycles", idle_small + 1, n);

		// periodic timeout measured over whole periods
		active_small = $urandom_range(2, MAX_ACTIVE);
		write_txn(reg_addr_rand(REG_ACTIVE), active_small, 4'hf, 1'b1);
		write_txn(reg_addr_rand(REG_RESET), $urandom, 4'hf, 1'b0);
		while (!o_sub_rst_n) @(posedge core_clk);
		while (o_sub_rst_n) @(posedge core_clk);
		repeat (3) begin
			n = 0;
			while (!o_sub_rst_n) begin
				n++;
				@(posedge core_clk);
			end
			check_data("hold low cycles", idle_small + 1, n);
			n = 0;
			while (o_sub_rst_n) begin
				n++;
				@(posedge core_clk);
			end
			check_data("run high cycles", active_small + 1, n);
		end
		// status reads land in both states
		repeat (8)
			read_txn(reg_addr_rand(REG_RESET));

		// contents after all resets
		read_txn(reg_addr_rand(REG_LED));
		for (int i = 0; i < N_WORDS; i++)
			read_txn(SRAM_BASE + ((base_word + i) << 2));
		repeat (2) @(posedge core_clk);

		print_counts();
		if (data_errs + resp_errs + id_errs + bit_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
design/sys_pkg.sv
design/sys_reset_seq.sv
design/sys_ctrl_regs.sv
design/axi_lite_decoder.sv
design/axi_lite_sram.sv
design/sys_top.sv
dv/tb_clock_gen.sv
dv/tb_sys_top.sv

// File: Bender.yml
package:
  name: sys_ctrl_subsystem

sources:
  - design/sys_pkg.sv
  - design/sys_reset_seq.sv
  - design/sys_ctrl_regs.sv
  - design/axi_lite_decoder.sv
  - design/axi_lite_sram.sv
  - design/sys_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_sys_top.sv
